// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - include_dirs:
      - source
    files:
      - source/mips_pkg.sv
      - source/mips_pipe_if.sv
      - source/fetch_stage.sv
      - source/register_file.sv
      - source/decode_stage.sv
      - source/alu.sv
      - source/execute_stage.sv
      - source/mem_wb_stage.sv
      - source/mips_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/mips_asserts.sv
      - test/mips_core_tb.sv

// ==== flist.f ====
+incdir+source
source/mips_pkg.sv
source/mips_pipe_if.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mips_core.sv
test/mips_asserts.sv
test/mips_core_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module alu (
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  mips_pkg::alu_op_t     op,
  output logic [`MIPS_XLEN-1:0] result
);
  import mips_pkg::*;

  always_comb
  begin
    case (op)
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_slt: result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      default: result = '0;
    endcase
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module decode_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  mips_pkg::instr_t            instr_d,
  input  logic                        regwrite_w,
  input  logic [`MIPS_REG_ADDR_W-1:0] writereg_w,
  input  logic [`MIPS_XLEN-1:0]       result_w,
  output logic                        stall,
  id_ex_if.decode                     id_ex
);
  import mips_pkg::*;

  ctrl_t                 ctrl_d;
  logic                  zero_ext;
  logic [`MIPS_XLEN-1:0] imm_d;
  logic [`MIPS_XLEN-1:0] rd1;
  logic [`MIPS_XLEN-1:0] rd2;
  logic [`MIPS_XLEN-1:0] rs_value_d;
  logic [`MIPS_XLEN-1:0] rt_value_d;

  // write-through from write-back, register 0 never matches
  function automatic logic [`MIPS_XLEN-1:0] bypass(
    input logic [`MIPS_REG_ADDR_W-1:0] src,
    input logic [`MIPS_XLEN-1:0]       regval
  );
    if (regwrite_w && (writereg_w != '0) && (writereg_w == src))
      return result_w;
    return regval;
  endfunction

  register_file rf (
    .clk (clk),
    .we  (regwrite_w),
    .ra1 (instr_d.r.rs),
    .ra2 (instr_d.r.rt),
    .wa  (writereg_w),
    .wd  (result_w),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  // ----------------------------------------------------------------------
  // main decoder
  always_comb
  begin
    ctrl_d   = '0;
    zero_ext = 1'b0;
    case (instr_d.r.op)
      `MIPS_OP_RTYPE:
      begin
        ctrl_d.regwrite  = 1'b1;
        ctrl_d.regdst    = 1'b1;
        ctrl_d.alu_class = class_rtype;
      end
      `MIPS_OP_LW:
      begin
        ctrl_d.regwrite = 1'b1;
        ctrl_d.memtoreg = 1'b1;
        ctrl_d.alusrc   = 1'b1;
      end
      `MIPS_OP_SW:
      begin
        ctrl_d.memwrite = 1'b1;
        ctrl_d.alusrc   = 1'b1;
      end
      `MIPS_OP_ADDI, `MIPS_OP_ADDIU:
      begin
        ctrl_d.regwrite = 1'b1;
        ctrl_d.alusrc   = 1'b1;
      end
      `MIPS_OP_ORI:
      begin
        ctrl_d.regwrite  = 1'b1;
        ctrl_d.alusrc    = 1'b1;
        ctrl_d.alu_class = class_or;
        zero_ext         = 1'b1;
      end
      `MIPS_OP_LUI:
      begin
        ctrl_d.regwrite = 1'b1;
        ctrl_d.alusrc   = 1'b1;
        ctrl_d.shiftl16 = 1'b1;
      end
      default:
      begin
        ctrl_d = '0;                      // unknown opcode, no-op
      end
    endcase
  end

  assign imm_d = zero_ext ? {16'b0, instr_d.i.imm16}
                          : {{16{instr_d.i.imm16[15]}}, instr_d.i.imm16};

  always_comb
  begin
    rs_value_d = bypass(instr_d.r.rs, rd1);
    rt_value_d = bypass(instr_d.r.rt, rd2);
  end

  // load in execute feeding this instruction
  assign stall = id_ex.ctrl.memtoreg &&
                 ((id_ex.instr.i.rt == instr_d.r.rs) || (id_ex.instr.i.rt == instr_d.r.rt));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_ex.ctrl     <= '0;
      id_ex.instr    <= '0;
      id_ex.rs_value <= '0;
      id_ex.rt_value <= '0;
      id_ex.imm      <= '0;
    end
    else
    begin
      id_ex.ctrl     <= stall ? ctrl_t'('0) : ctrl_d;   // bubble on stall
      id_ex.instr    <= instr_d;
      id_ex.rs_value <= rs_value_d;
      id_ex.rt_value <= rt_value_d;
      id_ex.imm      <= imm_d;
    end
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module execute_stage (
  input  logic                        clk,
  input  logic                        reset,
  id_ex_if.execute                    id_ex,
  input  logic                        regwrite_w,
  input  logic [`MIPS_REG_ADDR_W-1:0] writereg_w,
  input  logic [`MIPS_XLEN-1:0]       result_w,
  ex_mem_if.execute                   ex_mem
);
  import mips_pkg::*;

  alu_op_t                     alu_op;
  logic [`MIPS_XLEN-1:0]       src_a;
  logic [`MIPS_XLEN-1:0]       fwd_b;
  logic [`MIPS_XLEN-1:0]       imm_e;
  logic [`MIPS_XLEN-1:0]       src_b;
  logic [`MIPS_XLEN-1:0]       aluout_e;
  logic [`MIPS_REG_ADDR_W-1:0] writereg_e;

  // memory stage wins over write-back
  function automatic logic [`MIPS_XLEN-1:0] forward(
    input logic [`MIPS_REG_ADDR_W-1:0] src,
    input logic [`MIPS_XLEN-1:0]       regval
  );
    if (src == '0)
      return regval;
    if (ex_mem.regwrite && (ex_mem.writereg == src))
      return ex_mem.aluout;
    if (regwrite_w && (writereg_w == src))
      return result_w;
    return regval;
  endfunction

  // ----------------------------------------------------------------------
  // alu decoder
  always_comb
  begin
    case (id_ex.ctrl.alu_class)
      class_add: alu_op = alu_add;
      class_or:  alu_op = alu_or;
      class_rtype:
      begin
        case (id_ex.instr.r.funct)
          `MIPS_FN_ADD, `MIPS_FN_ADDU: alu_op = alu_add;
          `MIPS_FN_SUB, `MIPS_FN_SUBU: alu_op = alu_sub;
          `MIPS_FN_AND:                alu_op = alu_and;
          `MIPS_FN_OR:                 alu_op = alu_or;
          `MIPS_FN_SLT, `MIPS_FN_SLTU: alu_op = alu_slt;  // sltu treated as signed
          default:                     alu_op = alu_add;
        endcase
      end
      default:   alu_op = alu_add;
    endcase
  end

  always_comb
  begin
    src_a = forward(id_ex.instr.r.rs, id_ex.rs_value);
    fwd_b = forward(id_ex.instr.r.rt, id_ex.rt_value);
  end

  assign imm_e      = id_ex.ctrl.shiftl16 ? {id_ex.imm[15:0], 16'b0} : id_ex.imm;  // lui
  assign src_b      = id_ex.ctrl.alusrc ? imm_e : fwd_b;
  assign writereg_e = id_ex.ctrl.regdst ? id_ex.instr.r.rd : id_ex.instr.r.rt;

  alu u_alu (
    .a      (src_a),
    .b      (src_b),
    .op     (alu_op),
    .result (aluout_e)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_mem.aluout    <= '0;
      ex_mem.writedata <= '0;
      ex_mem.writereg  <= '0;
      ex_mem.regwrite  <= 1'b0;
      ex_mem.memtoreg  <= 1'b0;
      ex_mem.memwrite  <= 1'b0;
    end
    else
    begin
      ex_mem.aluout    <= aluout_e;
      ex_mem.writedata <= fwd_b;         // store data after forwarding
      ex_mem.writereg  <= writereg_e;
      ex_mem.regwrite  <= id_ex.ctrl.regwrite;
      ex_mem.memtoreg  <= id_ex.ctrl.memtoreg;
      ex_mem.memwrite  <= id_ex.ctrl.memwrite;
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic [`MIPS_XLEN-1:0] instr,
  output logic [`MIPS_XLEN-1:0] pc,
  output mips_pkg::instr_t      instr_d
);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc      <= '0;
      instr_d <= '0;                      // all-zero word is a no-op
    end
    else if (!stall)
    begin
      pc      <= pc + `MIPS_PC_STEP;
      instr_d <= instr;
    end
  end

endmodule

// ==== source/mem_wb_stage.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module mem_wb_stage (
  input  logic                        clk,
  input  logic                        reset,
  ex_mem_if.mem_wb                    ex_mem,
  output logic                        memwrite,
  output logic [`MIPS_XLEN-1:0]       memaddr,
  output logic [`MIPS_XLEN-1:0]       memwritedata,
  input  logic [`MIPS_XLEN-1:0]       memreaddata,
  output logic                        regwrite_w,
  output logic [`MIPS_REG_ADDR_W-1:0] writereg_w,
  output logic [`MIPS_XLEN-1:0]       result_w
);

  logic [`MIPS_XLEN-1:0] readdata_w;
  logic [`MIPS_XLEN-1:0] aluout_w;
  logic                  memtoreg_w;

  // data bus, single cycle
  assign memwrite     = ex_mem.memwrite;
  assign memaddr      = ex_mem.aluout;
  assign memwritedata = ex_mem.writedata;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      readdata_w <= '0;
      aluout_w   <= '0;
      writereg_w <= '0;
      regwrite_w <= 1'b0;
      memtoreg_w <= 1'b0;
    end
    else
    begin
      readdata_w <= memreaddata;          // read data valid with memaddr
      aluout_w   <= ex_mem.aluout;
      writereg_w <= ex_mem.writereg;
      regwrite_w <= ex_mem.regwrite;
      memtoreg_w <= ex_mem.memtoreg;
    end
  end

  assign result_w = memtoreg_w ? readdata_w : aluout_w;

endmodule

// ==== source/mips_core.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_core (
  input  logic                  clk,
  input  logic                  reset,
  output logic [`MIPS_XLEN-1:0] pc,
  input  logic [`MIPS_XLEN-1:0] instr,
  output logic                  memwrite,
  output logic [`MIPS_XLEN-1:0] memaddr,
  output logic [`MIPS_XLEN-1:0] memwritedata,
  input  logic [`MIPS_XLEN-1:0] memreaddata
);
  import mips_pkg::*;

  instr_t                      instr_d;
  logic                        stall;
  logic                        regwrite_w;
  logic [`MIPS_REG_ADDR_W-1:0] writereg_w;
  logic [`MIPS_XLEN-1:0]       result_w;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage u_fetch (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .instr   (instr),
    .pc      (pc),
    .instr_d (instr_d)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .instr_d    (instr_d),
    .regwrite_w (regwrite_w),
    .writereg_w (writereg_w),
    .result_w   (result_w),
    .stall      (stall),
    .id_ex      (id_ex.decode)
  );

  execute_stage u_execute (
    .clk        (clk),
    .reset      (reset),
    .id_ex      (id_ex.execute),
    .regwrite_w (regwrite_w),
    .writereg_w (writereg_w),
    .result_w   (result_w),
    .ex_mem     (ex_mem.execute)
  );

  mem_wb_stage u_mem_wb (
    .clk          (clk),
    .reset        (reset),
    .ex_mem       (ex_mem.mem_wb),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .memreaddata  (memreaddata),
    .regwrite_w   (regwrite_w),
    .writereg_w   (writereg_w),
    .result_w     (result_w)
  );

endmodule

// ==== source/mips_pipe_if.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

// ----------------------------------------------------------------------
// decode to execute register contents
interface id_ex_if;
  import mips_pkg::*;

  ctrl_t                ctrl;
  instr_t               instr;
  logic [`MIPS_XLEN-1:0] rs_value;
  logic [`MIPS_XLEN-1:0] rt_value;
  logic [`MIPS_XLEN-1:0] imm;

  modport decode (
    output ctrl,
    output instr,
    output rs_value,
    output rt_value,
    output imm
  );

  modport execute (
    input ctrl,
    input instr,
    input rs_value,
    input rt_value,
    input imm
  );
endinterface

// ----------------------------------------------------------------------
// execute to memory register contents
interface ex_mem_if;
  logic [`MIPS_XLEN-1:0]       aluout;
  logic [`MIPS_XLEN-1:0]       writedata;
  logic [`MIPS_REG_ADDR_W-1:0] writereg;
  logic                        regwrite;
  logic                        memtoreg;
  logic                        memwrite;

  modport execute (
    output aluout,
    output writedata,
    output writereg,
    output regwrite,
    output memtoreg,
    output memwrite
  );

  modport mem_wb (
    input aluout,
    input writedata,
    input writereg,
    input regwrite,
    input memtoreg,
    input memwrite
  );
endinterface

// ==== source/mips_pkg.sv ====
`include "mips_settings.svh"

package mips_pkg;

  typedef struct packed {
    logic [5:0]                  op;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [`MIPS_REG_ADDR_W-1:0] rd;
    logic [4:0]                  shamt;
    logic [5:0]                  funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]                  op;
    logic [`MIPS_REG_ADDR_W-1:0] rs;
    logic [`MIPS_REG_ADDR_W-1:0] rt;
    logic [15:0]                 imm16;
  } i_fields_t;

  // one fetched word, seen as r-type or i-type
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_t;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_t;

  typedef enum logic [1:0] {
    class_add   = 2'b00,
    class_or    = 2'b01,
    class_rtype = 2'b10
  } alu_class_t;

  typedef struct packed {
    logic       regwrite;
    logic       memtoreg;
    logic       memwrite;
    logic       alusrc;
    logic       regdst;
    logic       shiftl16;
    alu_class_t alu_class;
  } ctrl_t;

endpackage

// ==== source/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define MIPS_XLEN        32
`define MIPS_REG_ADDR_W  5
`define MIPS_NUM_REGS    32
`define MIPS_PC_STEP     32'd4

// ----------------------------------------------------------------------
// opcodes
`define MIPS_OP_RTYPE    6'b000000
`define MIPS_OP_LW       6'b100011
`define MIPS_OP_SW       6'b101011
`define MIPS_OP_ADDI     6'b001000
`define MIPS_OP_ADDIU    6'b001001
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_LUI      6'b001111

// ----------------------------------------------------------------------
// r-type function codes
`define MIPS_FN_ADD      6'b100000
`define MIPS_FN_ADDU     6'b100001
`define MIPS_FN_SUB      6'b100010
`define MIPS_FN_SUBU     6'b100011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_SLT      6'b101010
`define MIPS_FN_SLTU     6'b101011

`endif

// ==== source/register_file.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module register_file (
  input  logic                        clk,
  input  logic                        we,
  input  logic [`MIPS_REG_ADDR_W-1:0] ra1,
  input  logic [`MIPS_REG_ADDR_W-1:0] ra2,
  input  logic [`MIPS_REG_ADDR_W-1:0] wa,
  input  logic [`MIPS_XLEN-1:0]       wd,
  output logic [`MIPS_XLEN-1:0]       rd1,
  output logic [`MIPS_XLEN-1:0]       rd2
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (we && (wa != '0))
      regs[wa] <= wd;
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];   // $zero
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== test/mips_asserts.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic [`MIPS_XLEN-1:0] pc,
  input logic                  memwrite
);

  int assert_failures = 0;                  // read by the testbench at the end

  // ----------------------------------------------------------------------
  // data bus
  memwrite_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(memwrite))
  else
  begin
    $error("memwrite is unknown after reset");
    assert_failures++;
  end

  // ----------------------------------------------------------------------
  // pc, no branches so it steps or holds
  pc_step: assert property (@(posedge clk) disable iff (reset)
                            (pc == $past(pc)) || (pc == $past(pc) + `MIPS_PC_STEP))
  else
  begin
    $error("pc moved from %h to %h", $past(pc), pc);
    assert_failures++;
  end

  pc_in_reset: assert property (@(posedge clk) reset |-> (pc == '0))
  else
  begin
    $error("pc is %h while reset is held", pc);
    assert_failures++;
  end

endmodule

bind mips_core mips_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .pc       (pc),
  .memwrite (memwrite)
);

// ==== test/mips_core_tb.sv ====
`timescale 1ns/100ps
`include "mips_settings.svh"

module mips_core_tb;

  localparam int NUM_TESTS  = 14;
  localparam int MAX_WAIT   = 40;           // cycles allowed per test
  localparam int CLK_PERIOD = 4;
  localparam int PROG_WORDS = 16;
  localparam int DATA_WORDS = 64;

  localparam logic [5:0] op_addi = `MIPS_OP_ADDI;
  localparam logic [5:0] op_ori  = `MIPS_OP_ORI;
  localparam logic [5:0] op_lui  = `MIPS_OP_LUI;
  localparam logic [5:0] op_lw   = `MIPS_OP_LW;
  localparam logic [5:0] op_sw   = `MIPS_OP_SW;

  logic                  clk;
  logic                  reset;
  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] instr;
  logic                  memwrite;
  logic [`MIPS_XLEN-1:0] memaddr;
  logic [`MIPS_XLEN-1:0] memwritedata;
  logic [`MIPS_XLEN-1:0] memreaddata;

  logic [31:0] prog_mem [PROG_WORDS];
  logic [31:0] data_mem [DATA_WORDS];

  // test table
  string       test_name   [NUM_TESTS];
  int          skip_stores [NUM_TESTS];     // earlier stores ignored
  int          exp_cycle   [NUM_TESTS];     // cycles from reset release
  logic [31:0] exp_addr    [NUM_TESTS];
  logic [31:0] exp_data    [NUM_TESTS];
  logic [31:0] program_words [NUM_TESTS][$];

  int errors;
  int passed;
  int failed;

  mips_core DUT (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instr        (instr),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .memreaddata  (memreaddata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // ----------------------------------------------------------------------
  // memory models
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return ~addr;                             // unwritten word reads its address inverted
  endfunction

  function automatic logic [31:0] read_data(input logic [31:0] addr);
    if (addr < DATA_WORDS * 4)
      return data_mem[addr[7:2]];
    return fill_word(addr);
  endfunction

  always @(negedge clk)
  begin
    instr       <= (pc[31:2] < PROG_WORDS) ? prog_mem[pc[5:2]] : '0;
    memreaddata <= read_data(memaddr);
  end

  always @(posedge clk)
  begin
    if (memwrite && (memaddr < DATA_WORDS * 4))
      data_mem[memaddr[7:2]] <= memwritedata;
  end

  // ----------------------------------------------------------------------
  // table: $1 = 12, $2 = -5 for the r-type rows
  task automatic set_test(input int n, input string name, input int skip, input int cycle,
                          input logic [31:0] addr, input logic [31:0] data);
    test_name[n]   = name;
    skip_stores[n] = skip;
    exp_cycle[n]   = cycle;
    exp_addr[n]    = addr;
    exp_data[n]    = data;
  endtask

  task automatic build_table();
    set_test(0, "add", 0, 6, 32'h40, 32'h00000007);
    program_words[0] = {enc_i(op_addi, 1, 0, 16'd12), enc_i(op_addi, 2, 0, 16'hfffb),
                        enc_r(`MIPS_FN_ADD, 3, 2, 1), enc_i(op_sw, 3, 0, 16'h0040)};
    set_test(1, "sub", 0, 6, 32'h44, 32'hffffffef);
    program_words[1] = {enc_i(op_addi, 1, 0, 16'd12), enc_i(op_addi, 2, 0, 16'hfffb),
                        enc_r(`MIPS_FN_SUB, 3, 2, 1), enc_i(op_sw, 3, 0, 16'h0044)};
    set_test(2, "and", 0, 6, 32'h48, 32'h00000008);
    program_words[2] = {enc_i(op_addi, 1, 0, 16'd12), enc_i(op_addi, 2, 0, 16'hfffb),
                        enc_r(`MIPS_FN_AND, 3, 2, 1), enc_i(op_sw, 3, 0, 16'h0048)};
    set_test(3, "or", 0, 6, 32'h4c, 32'hffffffff);
    program_words[3] = {enc_i(op_addi, 1, 0, 16'd12), enc_i(op_addi, 2, 0, 16'hfffb),
                        enc_r(`MIPS_FN_OR, 3, 2, 1), enc_i(op_sw, 3, 0, 16'h004c)};
    set_test(4, "slt", 0, 6, 32'h50, 32'h00000001);
    program_words[4] = {enc_i(op_addi, 1, 0, 16'd12), enc_i(op_addi, 2, 0, 16'hfffb),
                        enc_r(`MIPS_FN_SLT, 3, 2, 1), enc_i(op_sw, 3, 0, 16'h0050)};
    set_test(5, "addi_negative", 0, 4, 32'h60, 32'hfffffffe);
    program_words[5] = {enc_i(op_addi, 4, 0, 16'hfffe), enc_i(op_sw, 4, 0, 16'h0060)};
    set_test(6, "ori_zero_extend", 0, 4, 32'h64, 32'h0000ffff);
    program_words[6] = {enc_i(op_ori, 5, 0, 16'hffff), enc_i(op_sw, 5, 0, 16'h0064)};
    set_test(7, "lui", 0, 4, 32'h68, 32'hbeef0000);
    program_words[7] = {enc_i(op_lui, 6, 0, 16'hbeef), enc_i(op_sw, 6, 0, 16'h0068)};
    set_test(8, "forward_mem", 0, 8, 32'h70, 32'd101);
    program_words[8] = {enc_i(op_addi, 1, 0, 16'd100), enc_i(op_addi, 2, 1, 16'd1),
                        32'h0, 32'h0, 32'h0, enc_i(op_sw, 2, 0, 16'h0070)};
    set_test(9, "forward_wb", 0, 9, 32'h74, 32'd201);
    program_words[9] = {enc_i(op_addi, 1, 0, 16'd200), 32'h0, enc_i(op_addi, 2, 1, 16'd1),
                        32'h0, 32'h0, 32'h0, enc_i(op_sw, 2, 0, 16'h0074)};
    set_test(10, "bypass_decode", 0, 10, 32'h78, 32'd301);
    program_words[10] = {enc_i(op_addi, 1, 0, 16'd300), 32'h0, 32'h0,
                         enc_i(op_addi, 2, 1, 16'd1), 32'h0, 32'h0, 32'h0,
                         enc_i(op_sw, 2, 0, 16'h0078)};
    // one stall cycle moves the second store from cycle 8 to 9
    set_test(11, "load_use", 1, 9, 32'ha4, 32'd12);
    program_words[11] = {enc_i(op_addi, 1, 0, 16'd5), enc_i(op_addi, 2, 0, 16'd7),
                         enc_i(op_sw, 1, 0, 16'h00a0), enc_i(op_lw, 3, 0, 16'h00a0),
                         enc_r(`MIPS_FN_ADD, 4, 3, 2), enc_i(op_sw, 4, 0, 16'h00a4)};
    set_test(12, "r0_store", 0, 4, 32'h80, 32'h0);
    program_words[12] = {enc_i(op_addi, 0, 0, 16'h0055), enc_i(op_sw, 0, 0, 16'h0080)};
    set_test(13, "r0_consumer", 0, 5, 32'h84, 32'd3);
    program_words[13] = {enc_i(op_addi, 0, 0, 16'h0055), enc_i(op_addi, 7, 0, 16'd3),
                         enc_i(op_sw, 7, 0, 16'h0084)};
  endtask

  // ----------------------------------------------------------------------
  // run loop
  task automatic restart(input int n);
    @(negedge clk);
    reset = 1'b1;
    for (int i = 0; i < PROG_WORDS; i++)
      prog_mem[i] = (i < program_words[n].size()) ? program_words[n][i] : 32'h0;
    for (int i = 0; i < DATA_WORDS; i++)
      data_mem[i] = fill_word(i * 4);
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic run_test(input int n);
    int cycles;
    int seen;
    bit found;
    int errors_before;
    cycles        = 0;
    seen          = 0;
    found         = 1'b0;
    errors_before = errors;
    restart(n);
    while (!found && (cycles < MAX_WAIT))
    begin
      @(negedge clk);                        // outputs settled since the rising edge
      cycles++;
      if (memwrite === 1'b1)
      begin
        if (seen == skip_stores[n])
          found = 1'b1;
        seen++;
      end
    end
    if (!found)
    begin
      $display("test %s: no store seen within %0d cycles", test_name[n], MAX_WAIT);
      errors++;
    end
    else
    begin
      check_value(test_name[n], "address", exp_addr[n], memaddr);
      check_value(test_name[n], "data", exp_data[n], memwritedata);
      check_value(test_name[n], "cycle", exp_cycle[n], cycles);
      if (errors == errors_before)
        $display("[ok] %s", test_name[n]);
    end
    if (errors == errors_before)
      passed++;
    else
      failed++;
  endtask

  initial
  begin
    reset       = 1'b1;
    instr       = '0;
    memreaddata = '0;
    errors      = 0;
    passed      = 0;
    failed      = 0;
    build_table();
    for (int n = 0; n < NUM_TESTS; n++)
      run_test(n);
    $display("tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             passed, failed, errors, DUT.u_asserts.assert_failures);
    if ((failed == 0) && (DUT.u_asserts.assert_failures == 0))
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // watchdog
  initial
  begin
    #((NUM_TESTS * (MAX_WAIT + 10) + 20) * CLK_PERIOD);
    $display("watchdog: the run did not finish in the allowed time");
    $display("** FAIL **");
    $finish;
  end

endmodule
